// ==== rtl/plic_pkg.sv ====
// Shared widths and register map for the single-hart, two-context PLIC
// Offsets are 24-bit byte offsets from the controller base, word aligned
`default_nettype none

package plic_pkg;

  // ================================================
  // Widths
  // ================================================

  // Priority 0 means the source never interrupts
  localparam int prio_w = 3;

  // Source ID, 0 is reserved and means "no interrupt"
  localparam int id_w = 5;

  // Upper bound for NUM_SOURCES
  localparam int max_sources = 32;

  // Bus offset and data widths
  localparam int addr_w = 24;
  localparam int data_w = 32;

  // ================================================
  // Register offsets
  // ================================================

  // Priority words live below this offset, source number in addr[6:2]
  localparam logic [addr_w-1:0] off_priority_hi = 24'h001000;

  // Pending word, read only
  localparam logic [addr_w-1:0] off_pending     = 24'h001000;

  // Enable words, one per context
  localparam logic [addr_w-1:0] off_enable_m    = 24'h002000;
  localparam logic [addr_w-1:0] off_enable_s    = 24'h002080;

  // Threshold and claim/complete, M context then S context
  localparam logic [addr_w-1:0] off_threshold_m = 24'h200000;
  localparam logic [addr_w-1:0] off_claim_m     = 24'h200004;
  localparam logic [addr_w-1:0] off_threshold_s = 24'h201000;
  localparam logic [addr_w-1:0] off_claim_s     = 24'h201004;

endpackage

`default_nettype wire

// ==== rtl/plic_gateway.sv ====
// Level-sensitive sources only; a claimed source stays blocked until completed
// Source 0 is reserved and never pends
`timescale 1ns/1ps
`default_nettype none

module plic_gateway #(
  parameter int NUM_SOURCES = 32
) (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic [NUM_SOURCES-1:0]      irq_sources,
  input  logic                        claim_valid,
  input  logic [plic_pkg::id_w-1:0]   claim_id,
  input  logic                        complete_valid,
  input  logic [plic_pkg::id_w-1:0]   complete_id,
  output logic [NUM_SOURCES-1:0]      pending
);

  // Per-source state
  logic [NUM_SOURCES-1:0] pending_q;
  logic [NUM_SOURCES-1:0] in_service_q;

  // One-hot decode of the strobes, and new requests from the sources
  logic [NUM_SOURCES-1:0] claim_hit;
  logic [NUM_SOURCES-1:0] complete_hit;
  logic [NUM_SOURCES-1:0] set_hit;

  // Loops start at 1 so bit 0 never decodes
  always_comb begin
    claim_hit    = '0;
    complete_hit = '0;
    for (int i = 1; i < NUM_SOURCES; i++) begin
      claim_hit[i]    = claim_valid && (int'(claim_id) == i);
      complete_hit[i] = complete_valid && (int'(complete_id) == i);
    end
  end

  // A level only pends while the source is idle in both states
  always_comb begin
    set_hit    = irq_sources & ~pending_q & ~in_service_q;
    set_hit[0] = 1'b0;
  end

  // Claim moves pending to in-service
  // Completion of an ID not in service falls out of the AND
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pending_q    <= '0;
      in_service_q <= '0;
    end else begin
      pending_q    <= (pending_q | set_hit) & ~claim_hit;
      in_service_q <= (in_service_q & ~complete_hit) | claim_hit;
    end
  end

  assign pending = pending_q;

  // ================================================
  // Checks
  // ================================================

  initial begin
    assert (NUM_SOURCES >= 2 && NUM_SOURCES <= plic_pkg::max_sources)
      else $error("NUM_SOURCES out of range");
  end

  // Strobes from the register file must name a real source
  a_ids_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    (claim_valid |-> int'(claim_id) < NUM_SOURCES) and
    (complete_valid |-> int'(complete_id) < NUM_SOURCES));

endmodule

`default_nettype wire

// ==== rtl/plic_arbiter.sv ====
// Combinational arbiter for one context; ties go to the lowest source ID
// clk and reset_n only clock the consistency check
`timescale 1ns/1ps
`default_nettype none

module plic_arbiter #(
  parameter int NUM_SOURCES = 32
) (
  input  logic                                   clk,
  input  logic                                   reset_n,
  input  logic [NUM_SOURCES-1:0]                 pending,
  input  logic [NUM_SOURCES-1:0]                 enable,
  input  logic [NUM_SOURCES*plic_pkg::prio_w-1:0] prio_flat,
  input  logic [plic_pkg::prio_w-1:0]            threshold,
  output logic [plic_pkg::id_w-1:0]              best_id,
  output logic                                   eip
);

  // Sources that could interrupt this context right now
  logic [NUM_SOURCES-1:0] eligible;

  // Priority of the current winner during the search
  logic [plic_pkg::prio_w-1:0] best_prio;

  // ================================================
  // Eligibility
  // ================================================

  // Strictly above threshold, so threshold 7 masks everything
  always_comb begin
    eligible = '0;
    for (int i = 1; i < NUM_SOURCES; i++) begin
      eligible[i] = pending[i] && enable[i] &&
                    (prio_flat[i*plic_pkg::prio_w +: plic_pkg::prio_w] > threshold);
    end
  end

  // ================================================
  // Priority search
  // ================================================

  // Ascending scan with a strict compare keeps the lowest ID on a tie
  always_comb begin : search
    logic [plic_pkg::prio_w-1:0] prio_i;
    best_id   = '0;
    best_prio = '0;
    for (int i = 1; i < NUM_SOURCES; i++) begin
      prio_i = prio_flat[i*plic_pkg::prio_w +: plic_pkg::prio_w];
      if (eligible[i] && (prio_i > best_prio)) begin
        best_id   = i[plic_pkg::id_w-1:0];
        best_prio = prio_i;
      end
    end
  end

  // Interrupt line straight from the eligible set
  assign eip = |eligible;

  // ================================================
  // Checks
  // ================================================

  // Line and claim ID come from separate paths, they must agree
  a_eip_matches_id: assert property (@(posedge clk) disable iff (!reset_n)
    eip == (best_id != '0));

endmodule

`default_nettype wire

// ==== rtl/plic_regs.sv ====
// Word-wide register bus with a one-entry response buffer, no byte lanes
// Claim side effects happen at request acceptance, never at response
`timescale 1ns/1ps
`default_nettype none

module plic_regs #(
  parameter int NUM_SOURCES = 32
) (
  input  logic                                    clk,
  input  logic                                    reset_n,

  // Request channel
  input  logic                                    req_valid,
  input  logic [plic_pkg::addr_w-1:0]             req_addr,
  input  logic                                    req_we,
  input  logic [plic_pkg::data_w-1:0]             req_wdata,
  output logic                                    req_ready,

  // Response channel
  output logic                                    rsp_valid,
  input  logic                                    rsp_ready,
  output logic [plic_pkg::data_w-1:0]             rsp_rdata,

  // Gateway and arbiter side
  input  logic [NUM_SOURCES-1:0]                  pending,
  input  logic [plic_pkg::id_w-1:0]               best_id_m,
  input  logic [plic_pkg::id_w-1:0]               best_id_s,
  output logic [NUM_SOURCES*plic_pkg::prio_w-1:0] prio_flat,
  output logic [NUM_SOURCES-1:0]                  enable_m,
  output logic [NUM_SOURCES-1:0]                  enable_s,
  output logic [plic_pkg::prio_w-1:0]             threshold_m,
  output logic [plic_pkg::prio_w-1:0]             threshold_s,
  output logic                                    claim_valid,
  output logic [plic_pkg::id_w-1:0]               claim_id,
  output logic                                    complete_valid,
  output logic [plic_pkg::id_w-1:0]               complete_id
);

  localparam int PW = plic_pkg::prio_w;

  // Configuration state
  logic [NUM_SOURCES*PW-1:0]       prio_q;
  logic [NUM_SOURCES-1:0]          enable_m_q;
  logic [NUM_SOURCES-1:0]          enable_s_q;
  logic [PW-1:0]                   threshold_m_q;
  logic [PW-1:0]                   threshold_s_q;

  // Response buffer
  logic                            rsp_valid_q;
  logic [plic_pkg::data_w-1:0]     rsp_rdata_q;

  // Decode
  logic                            is_prio;
  logic                            is_pending;
  logic                            is_en_m;
  logic                            is_en_s;
  logic                            is_thr_m;
  logic                            is_claim_m;
  logic                            is_thr_s;
  logic                            is_claim_s;
  logic [4:0]                      prio_src;
  logic                            prio_ok;

  // Handshake
  logic                            accept;
  logic                            wr_en;
  logic                            rd_en;
  logic [plic_pkg::data_w-1:0]     rd_data;

  // ================================================
  // Handshake
  // ================================================

  // Ready while the buffer is empty or drains this cycle
  assign req_ready = !rsp_valid_q || rsp_ready;
  assign accept    = req_valid && req_ready;
  assign wr_en     = accept && req_we;
  assign rd_en     = accept && !req_we;

  // ================================================
  // Address decode
  // ================================================

  assign is_prio    = (req_addr < plic_pkg::off_priority_hi);
  assign is_pending = (req_addr == plic_pkg::off_pending);
  assign is_en_m    = (req_addr == plic_pkg::off_enable_m);
  assign is_en_s    = (req_addr == plic_pkg::off_enable_s);
  assign is_thr_m   = (req_addr == plic_pkg::off_threshold_m);
  assign is_claim_m = (req_addr == plic_pkg::off_claim_m);
  assign is_thr_s   = (req_addr == plic_pkg::off_threshold_s);
  assign is_claim_s = (req_addr == plic_pkg::off_claim_s);

  // One priority word per source
  assign prio_src = req_addr[6:2];
  assign prio_ok  = is_prio && (int'(prio_src) < NUM_SOURCES);

  // ================================================
  // Read mux
  // ================================================

  // Anything unmapped reads 0
  always_comb begin
    rd_data = '0;
    if (prio_ok) begin
      rd_data[PW-1:0] = prio_q[int'(prio_src)*PW +: PW];
    end else if (is_pending) begin
      rd_data[NUM_SOURCES-1:0] = pending;
    end else if (is_en_m) begin
      rd_data[NUM_SOURCES-1:0] = enable_m_q;
    end else if (is_en_s) begin
      rd_data[NUM_SOURCES-1:0] = enable_s_q;
    end else if (is_thr_m) begin
      rd_data[PW-1:0] = threshold_m_q;
    end else if (is_thr_s) begin
      rd_data[PW-1:0] = threshold_s_q;
    end else if (is_claim_m) begin
      rd_data[plic_pkg::id_w-1:0] = best_id_m;
    end else if (is_claim_s) begin
      rd_data[plic_pkg::id_w-1:0] = best_id_s;
    end
  end

  // ================================================
  // Claim and complete strobes
  // ================================================

  // Claim ID follows the context addressed
  assign claim_id    = is_claim_m ? best_id_m : best_id_s;
  assign claim_valid = rd_en && (is_claim_m || is_claim_s) && (claim_id != '0);

  // Any ID goes to the gateway, which drops ones not in service
  assign complete_id    = req_wdata[plic_pkg::id_w-1:0];
  assign complete_valid = wr_en && (is_claim_m || is_claim_s);

  // ================================================
  // Configuration registers
  // ================================================

  // Source 0 priority is never written, so it stays 0
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      prio_q        <= '0;
      enable_m_q    <= '0;
      enable_s_q    <= '0;
      threshold_m_q <= '0;
      threshold_s_q <= '0;
    end else if (wr_en) begin
      if (prio_ok && (prio_src != '0)) begin
        prio_q[int'(prio_src)*PW +: PW] <= req_wdata[PW-1:0];
      end
      if (is_en_m) begin
        enable_m_q <= req_wdata[NUM_SOURCES-1:0];
      end
      if (is_en_s) begin
        enable_s_q <= req_wdata[NUM_SOURCES-1:0];
      end
      if (is_thr_m) begin
        threshold_m_q <= req_wdata[PW-1:0];
      end
      if (is_thr_s) begin
        threshold_s_q <= req_wdata[PW-1:0];
      end
    end
  end

  assign prio_flat   = prio_q;
  assign enable_m    = enable_m_q;
  assign enable_s    = enable_s_q;
  assign threshold_m = threshold_m_q;
  assign threshold_s = threshold_s_q;

  // ================================================
  // Response buffer
  // ================================================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Data only loads on acceptance, writes answer 0
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_rdata_q <= req_we ? '0 : rd_data;
    end
  end

  assign rsp_valid = rsp_valid_q;
  assign rsp_rdata = rsp_rdata_q;

  // ================================================
  // Checks
  // ================================================

  // Stalled response holds
  a_rsp_stable: assert property (@(posedge clk) disable iff (!reset_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata));

  // A claim only ever names a source the gateway holds pending
  a_claim_pending: assert property (@(posedge clk) disable iff (!reset_n)
    claim_valid |-> pending[claim_id]);

endmodule

`default_nettype wire

// ==== rtl/plic_top.sv ====
// Single hart, M and S contexts, level-sensitive sources 1 to NUM_SOURCES-1
// NUM_SOURCES from 2 to 32, passed down to every block
`timescale 1ns/1ps
`default_nettype none

module plic_top #(
  parameter int NUM_SOURCES = 32
) (
  input  logic                              clk,
  input  logic                              reset_n,

  // Register bus
  input  logic                              req_valid,
  input  logic [plic_pkg::addr_w-1:0]       req_addr,
  input  logic                              req_we,
  input  logic [plic_pkg::data_w-1:0]       req_wdata,
  output logic                              req_ready,
  output logic                              rsp_valid,
  input  logic                              rsp_ready,
  output logic [plic_pkg::data_w-1:0]       rsp_rdata,

  // Interrupt sources and context lines
  input  logic [NUM_SOURCES-1:0]            irq_sources,
  output logic                              mei,
  output logic                              sei
);

  // ================================================
  // Internal nets
  // ================================================

  logic [NUM_SOURCES-1:0]                  pending;
  logic [NUM_SOURCES*plic_pkg::prio_w-1:0] prio_flat;
  logic [NUM_SOURCES-1:0]                  enable_m;
  logic [NUM_SOURCES-1:0]                  enable_s;
  logic [plic_pkg::prio_w-1:0]             threshold_m;
  logic [plic_pkg::prio_w-1:0]             threshold_s;
  logic [plic_pkg::id_w-1:0]               best_id_m;
  logic [plic_pkg::id_w-1:0]               best_id_s;
  logic                                    claim_valid;
  logic [plic_pkg::id_w-1:0]               claim_id;
  logic                                    complete_valid;
  logic [plic_pkg::id_w-1:0]               complete_id;

  // ================================================
  // Instances
  // ================================================

  plic_gateway #(.NUM_SOURCES(NUM_SOURCES)) u_gateway (
    .clk            (clk),
    .reset_n        (reset_n),
    .irq_sources    (irq_sources),
    .claim_valid    (claim_valid),
    .claim_id       (claim_id),
    .complete_valid (complete_valid),
    .complete_id    (complete_id),
    .pending        (pending)
  );

  // Machine context
  plic_arbiter #(.NUM_SOURCES(NUM_SOURCES)) u_arb_m (
    .clk       (clk),
    .reset_n   (reset_n),
    .pending   (pending),
    .enable    (enable_m),
    .prio_flat (prio_flat),
    .threshold (threshold_m),
    .best_id   (best_id_m),
    .eip       (mei)
  );

  // Supervisor context
  plic_arbiter #(.NUM_SOURCES(NUM_SOURCES)) u_arb_s (
    .clk       (clk),
    .reset_n   (reset_n),
    .pending   (pending),
    .enable    (enable_s),
    .prio_flat (prio_flat),
    .threshold (threshold_s),
    .best_id   (best_id_s),
    .eip       (sei)
  );

  plic_regs #(.NUM_SOURCES(NUM_SOURCES)) u_regs (
    .clk            (clk),
    .reset_n        (reset_n),
    .req_valid      (req_valid),
    .req_addr       (req_addr),
    .req_we         (req_we),
    .req_wdata      (req_wdata),
    .req_ready      (req_ready),
    .rsp_valid      (rsp_valid),
    .rsp_ready      (rsp_ready),
    .rsp_rdata      (rsp_rdata),
    .pending        (pending),
    .best_id_m      (best_id_m),
    .best_id_s      (best_id_s),
    .prio_flat      (prio_flat),
    .enable_m       (enable_m),
    .enable_s       (enable_s),
    .threshold_m    (threshold_m),
    .threshold_s    (threshold_s),
    .claim_valid    (claim_valid),
    .claim_id       (claim_id),
    .complete_valid (complete_valid),
    .complete_id    (complete_id)
  );

endmodule

`default_nettype wire

// ==== testbench/plic_tb.sv ====
// Directed testbench for plic_top with 32 sources, checked against a reference model
// Inputs change 1 ns after the rising edge; rsp_ready stays high except under stall test
`timescale 1ns/1ps
`default_nettype none

module plic_tb;

  localparam int num_src        = 32;
  localparam int timeout_cycles = 200;

  // DUT signals
  logic        clk;
  logic        reset_n;
  logic        req_valid;
  logic [23:0] req_addr;
  logic        req_we;
  logic [31:0] req_wdata;
  logic        req_ready;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [31:0] rsp_rdata;
  logic [31:0] irq_sources;
  logic        mei;
  logic        sei;

  // Reference model of gateway and configuration state
  logic [2:0]  m_prio [num_src];
  logic [31:0] m_en_m;
  logic [31:0] m_en_s;
  logic [2:0]  m_thr_m;
  logic [2:0]  m_thr_s;
  logic [31:0] m_pend;
  logic [31:0] m_insvc;

  // Bookkeeping
  int    err_count;
  int    tests_run;
  int    tests_failed;
  string cur_test;

  plic_top #(.NUM_SOURCES(num_src)) uut (
    .clk         (clk),
    .reset_n     (reset_n),
    .req_valid   (req_valid),
    .req_addr    (req_addr),
    .req_we      (req_we),
    .req_wdata   (req_wdata),
    .req_ready   (req_ready),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp_rdata   (rsp_rdata),
    .irq_sources (irq_sources),
    .mei         (mei),
    .sei         (sei)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // ==================================================
  // Model and checks
  // ==================================================

  // Highest priority above threshold wins, lowest ID on a tie
  function automatic logic [4:0] ref_best(input logic [31:0] en, input logic [2:0] thr);
    logic [4:0] id;
    logic [2:0] top;
    id  = '0;
    top = '0;
    for (int i = 1; i < num_src; i++) begin
      if (m_pend[i] && en[i] && (m_prio[i] > thr) && (m_prio[i] > top)) begin
        id  = 5'(i);
        top = m_prio[i];
      end
    end
    return id;
  endfunction

  // Level sources pend when idle in both states; bit 0 never pends
  function automatic void settle_model();
    m_pend = (m_pend | (irq_sources & ~m_insvc)) & ~32'h1;
  endfunction

  function automatic logic [23:0] prio_addr(input int s);
    return {17'b0, 5'(s), 2'b00};
  endfunction

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("TIMEOUT in %s: %s", cur_test, what);
    $display("*** FAILED ***");
    $finish;
  endtask

  // Both lines against the model
  task automatic check_lines();
    check_word("mei", {31'b0, ref_best(m_en_m, m_thr_m) != 5'd0}, {31'b0, mei});
    check_word("sei", {31'b0, ref_best(m_en_s, m_thr_s) != 5'd0}, {31'b0, sei});
  endtask

  task automatic finish_test(input string name, input int start_errs);
    tests_run++;
    if (err_count == start_errs) begin
      $display("[%0t] %s: pass", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t] %s: FAIL with %0d errors", $time, name, err_count - start_errs);
    end
  endtask

  // ==================================================
  // Bus and source drivers
  // ==================================================

  task automatic advance(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Present a request and return just after the accepting edge
  task automatic bus_request(input logic [23:0] addr, input logic we, input logic [31:0] wdata);
    int cnt;
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req_addr  = addr;
    req_we    = we;
    req_wdata = wdata;
    cnt = 0;
    while (!req_ready) begin
      if (cnt == timeout_cycles) abort_run("req_ready stayed low");
      advance(1);
      cnt++;
    end
    advance(1);
    req_valid = 1'b0;
    req_addr  = '0;
    req_we    = 1'b0;
    req_wdata = '0;
  endtask

  task automatic bus_response(output logic [31:0] data);
    int cnt;
    cnt = 0;
    while (!rsp_valid) begin
      if (cnt == timeout_cycles) abort_run("rsp_valid never rose");
      advance(1);
      cnt++;
    end
    data = rsp_rdata;
  endtask

  // Writes always answer 0
  task automatic bus_write(input logic [23:0] addr, input logic [31:0] data);
    logic [31:0] d;
    bus_request(addr, 1'b1, data);
    bus_response(d);
    check_word("write response", 32'd0, d);
  endtask

  task automatic bus_read(input logic [23:0] addr, output logic [31:0] data);
    bus_request(addr, 1'b0, 32'd0);
    bus_response(data);
  endtask

  task automatic write_prio(input int src, input logic [2:0] p);
    bus_write(prio_addr(src), {29'b0, p});
    if (src != 0) m_prio[src] = p;
  endtask

  task automatic write_enable(input logic ctx, input logic [31:0] v);
    bus_write(ctx ? plic_pkg::off_enable_s : plic_pkg::off_enable_m, v);
    if (ctx) m_en_s = v;
    else m_en_m = v;
  endtask

  task automatic write_thr(input logic ctx, input logic [2:0] t);
    bus_write(ctx ? plic_pkg::off_threshold_s : plic_pkg::off_threshold_m, {29'b0, t});
    if (ctx) m_thr_s = t;
    else m_thr_m = t;
  endtask

  // Claim read, checked against the model, which then moves the ID to in-service
  task automatic do_claim(input logic ctx, output logic [4:0] id);
    logic [4:0]  exp;
    logic [31:0] d;
    exp = ctx ? ref_best(m_en_s, m_thr_s) : ref_best(m_en_m, m_thr_m);
    bus_read(ctx ? plic_pkg::off_claim_s : plic_pkg::off_claim_m, d);
    check_word("claim id", {27'b0, exp}, d);
    if (exp != 5'd0) begin
      m_pend[exp]  = 1'b0;
      m_insvc[exp] = 1'b1;
    end
    id = d[4:0];
  endtask

  // IDs not in service are dropped
  // A freed source pends again one edge after the completion
  task automatic do_complete(input logic ctx, input logic [4:0] id);
    bus_write(ctx ? plic_pkg::off_claim_s : plic_pkg::off_claim_m, {27'b0, id});
    if (id != 5'd0) m_insvc[id] = 1'b0;
    advance(1);
    settle_model();
  endtask

  task automatic check_pending();
    logic [31:0] d;
    bus_read(plic_pkg::off_pending, d);
    check_word("pending word", m_pend, d);
  endtask

  // Sources pend on the first edge, lines follow combinationally
  task automatic set_sources(input logic [31:0] v);
    irq_sources = v;
    advance(1);
    settle_model();
  endtask

  // Drop sources, finish every claim and claim away leftovers through M
  task automatic drain();
    logic [4:0] id;
    irq_sources = '0;
    advance(1);
    for (int i = 1; i < num_src; i++) begin
      if (m_insvc[i]) do_complete(1'b0, 5'(i));
    end
    for (int i = 1; i < num_src; i++) begin
      if (m_pend[i] && (m_prio[i] == 3'd0)) write_prio(i, 3'd1);
    end
    write_enable(1'b0, 32'hFFFF_FFFE);
    write_thr(1'b0, 3'd0);
    for (int n = 0; n < num_src && m_pend != '0; n++) begin
      do_claim(1'b0, id);
      do_complete(1'b0, id);
    end
    write_enable(1'b0, 32'd0);
    write_enable(1'b1, 32'd0);
    check_pending();
  endtask

  // ==================================================
  // Directed tests
  // ==================================================

  task automatic test_readback();
    int          start;
    logic [31:0] r;
    logic [31:0] d;
    start    = err_count;
    cur_test = "readback";
    // State right after reset
    check_word("req_ready", 32'd1, {31'b0, req_ready});
    check_word("rsp_valid", 32'd0, {31'b0, rsp_valid});
    check_word("mei", 32'd0, {31'b0, mei});
    check_word("sei", 32'd0, {31'b0, sei});
    for (int s = 1; s < num_src; s++) begin
      r = $urandom();
      write_prio(s, r[2:0]);
    end
    // Source 0 ignores the write
    write_prio(0, 3'd7);
    for (int s = 0; s < num_src; s++) begin
      bus_read(prio_addr(s), d);
      check_word("priority", {29'b0, m_prio[s]}, d);
    end
    write_enable(1'b0, $urandom());
    write_enable(1'b1, $urandom());
    r = $urandom();
    write_thr(1'b0, r[2:0]);
    write_thr(1'b1, r[6:4]);
    bus_read(plic_pkg::off_enable_m, d);
    check_word("enable m", m_en_m, d);
    bus_read(plic_pkg::off_enable_s, d);
    check_word("enable s", m_en_s, d);
    bus_read(plic_pkg::off_threshold_m, d);
    check_word("threshold m", {29'b0, m_thr_m}, d);
    bus_read(plic_pkg::off_threshold_s, d);
    check_word("threshold s", {29'b0, m_thr_s}, d);
    // Holes in the map
    bus_read(24'h003000, d);
    check_word("unmapped read", 32'd0, d);
    bus_read(24'h300000, d);
    check_word("unmapped read", 32'd0, d);
    write_enable(1'b0, 32'd0);
    write_enable(1'b1, 32'd0);
    finish_test("readback", start);
  endtask

  task automatic test_pending_mask();
    int          start;
    logic [31:0] d;
    start    = err_count;
    cur_test = "pending_mask";
    write_prio(3, 3'd5);
    write_thr(1'b0, 3'd2);
    write_enable(1'b0, 32'h0000_0008);
    set_sources(32'h0000_0008);
    check_word("mei raised", 32'd1, {31'b0, mei});
    bus_read(plic_pkg::off_pending, d);
    check_word("pending source 3", 32'h0000_0008, d);
    // Threshold at the priority masks the line, pending stays
    write_thr(1'b0, 3'd5);
    check_word("mei masked", 32'd0, {31'b0, mei});
    bus_read(plic_pkg::off_pending, d);
    check_word("pending kept", 32'h0000_0008, d);
    // Source 7 is never enabled
    write_prio(7, 3'd7);
    set_sources(32'h0000_0088);
    check_word("mei disabled source", 32'd0, {31'b0, mei});
    check_lines();
    check_pending();
    drain();
    finish_test("pending_mask", start);
  endtask

  task automatic test_arbitration();
    int          start;
    logic [31:0] r;
    logic [31:0] mask;
    logic [4:0]  id;
    start    = err_count;
    cur_test = "arbitration";
    mask     = '0;
    // Priorities 1 to 4 so ties are common
    for (int s = 1; s < num_src; s++) begin
      r = $urandom();
      if (r[9] || s == 1) begin
        mask[s] = 1'b1;
        write_prio(s, 3'(r[4:3]) + 3'd1);
      end
    end
    write_enable(1'b0, 32'hFFFF_FFFE);
    // Priority 1 sources stay below threshold
    write_thr(1'b0, 3'd1);
    set_sources(mask);
    check_lines();
    for (int n = 0; n <= num_src; n++) begin
      do_claim(1'b0, id);
      check_lines();
      if (id == 5'd0) break;
    end
    // Nothing eligible left
    do_claim(1'b0, id);
    check_word("empty claim", 32'd0, {27'b0, id});
    drain();
    finish_test("arbitration", start);
  endtask

  task automatic test_claim_complete();
    int         start;
    logic [4:0] id;
    start    = err_count;
    cur_test = "claim_complete";
    write_prio(9, 3'd4);
    write_thr(1'b0, 3'd0);
    write_enable(1'b0, 32'h0000_0200);
    set_sources(32'h0000_0200);
    do_claim(1'b0, id);
    check_word("claimed id", 32'd9, {27'b0, id});
    check_pending();
    // Line still high, must not pend again
    advance(4);
    settle_model();
    check_pending();
    check_lines();
    // Wrong ID is ignored
    do_complete(1'b0, 5'd10);
    advance(2);
    settle_model();
    check_pending();
    check_word("mei after wrong id", 32'd0, {31'b0, mei});
    do_complete(1'b0, 5'd9);
    advance(1);
    settle_model();
    check_pending();
    check_word("mei after complete", 32'd1, {31'b0, mei});
    drain();
    finish_test("claim_complete", start);
  endtask

  task automatic test_contexts();
    int         start;
    logic [4:0] id;
    start    = err_count;
    cur_test = "contexts";
    write_prio(12, 3'd3);
    write_prio(14, 3'd6);
    write_enable(1'b0, 32'h0000_4000);
    write_enable(1'b1, 32'h0000_1000);
    write_thr(1'b0, 3'd0);
    write_thr(1'b1, 3'd0);
    set_sources(32'h0000_1000);
    check_word("sei for s source", 32'd1, {31'b0, sei});
    check_word("mei for s source", 32'd0, {31'b0, mei});
    set_sources(32'h0000_5000);
    check_lines();
    // M holds 14 while S works on 12
    do_claim(1'b0, id);
    check_word("m claim", 32'd14, {27'b0, id});
    check_lines();
    do_claim(1'b1, id);
    check_word("s claim", 32'd12, {27'b0, id});
    check_lines();
    do_complete(1'b1, 5'd12);
    check_pending();
    check_word("sei re-raised", 32'd1, {31'b0, sei});
    check_word("mei while claimed", 32'd0, {31'b0, mei});
    do_claim(1'b1, id);
    do_complete(1'b1, id);
    do_complete(1'b0, 5'd14);
    check_lines();
    check_pending();
    drain();
    finish_test("contexts", start);
  endtask

  task automatic test_backpressure();
    int          start;
    logic [4:0]  exp;
    logic [4:0]  id;
    logic [31:0] held;
    start    = err_count;
    cur_test = "backpressure";
    write_prio(5, 3'd2);
    write_prio(6, 3'd2);
    write_enable(1'b0, 32'h0000_0060);
    write_thr(1'b0, 3'd0);
    set_sources(32'h0000_0060);
    exp = ref_best(m_en_m, m_thr_m);
    // Claim read with the response stalled
    rsp_ready = 1'b0;
    bus_request(plic_pkg::off_claim_m, 1'b0, 32'd0);
    bus_response(held);
    check_word("stalled claim", {27'b0, exp}, held);
    check_word("tie to lowest id", 32'd5, held);
    m_pend[exp]  = 1'b0;
    m_insvc[exp] = 1'b1;
    for (int n = 0; n < 6; n++) begin
      advance(1);
      check_word("rsp_valid held", 32'd1, {31'b0, rsp_valid});
      check_word("rsp_rdata held", held, rsp_rdata);
      check_word("req_ready low", 32'd0, {31'b0, req_ready});
    end
    rsp_ready = 1'b1;
    advance(1);
    check_word("rsp_valid drained", 32'd0, {31'b0, rsp_valid});
    // Side effect happened once, the next claim moves on
    do_claim(1'b0, id);
    check_word("second claim", 32'd6, {27'b0, id});
    drain();
    finish_test("backpressure", start);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================

  initial begin
    clk          = 1'b0;
    reset_n      = 1'b0;
    req_valid    = 1'b0;
    req_addr     = '0;
    req_we       = 1'b0;
    req_wdata    = '0;
    rsp_ready    = 1'b1;
    irq_sources  = '0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_test     = "reset";
    m_en_m       = '0;
    m_en_s       = '0;
    m_thr_m      = '0;
    m_thr_s      = '0;
    m_pend       = '0;
    m_insvc      = '0;
    for (int i = 0; i < num_src; i++) begin
      m_prio[i] = '0;
    end
    void'($urandom(63));
    repeat (16) @(posedge clk);
    #1;
    reset_n = 1'b1;

    test_readback();
    test_pending_mask();
    test_arbitration();
    test_claim_complete();
    test_contexts();
    test_backpressure();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/plic_pkg.sv
rtl/plic_gateway.sv
rtl/plic_arbiter.sv
rtl/plic_regs.sv
rtl/plic_top.sv
testbench/plic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PLIC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module plic_tb -o plic_sim

# Pass or fail is decided by the testbench's own message
out=$(./obj_dir/plic_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1
